/* rtl/fifo_cfg_pkg.sv */
package fifo_cfg_pkg;

   // width of a word on the write port
   localparam int W_DATA_W = 32;

   // width of a byte on the read port
   localparam int R_DATA_W = 8;

   // byte address width, sets the buffer depth
   localparam int ADDR_W = 4;

   // buffer depth counted in bytes
   localparam int FIFO_SIZE = 1 << ADDR_W;

   // bytes carried by one write word
   localparam int RATIO = W_DATA_W / R_DATA_W;

   // shift from word units to byte units
   localparam int RATIO_LOG = $clog2(RATIO);

   // write side addresses whole words
   localparam int W_ADDR_W = ADDR_W - RATIO_LOG;

   // read side addresses single bytes
   localparam int R_ADDR_W = ADDR_W;

   // bytes consumed per accepted access on each side
   localparam int W_INCR = RATIO;
   localparam int R_INCR = 1;

endpackage

/* rtl/fifo_types_pkg.sv */
package fifo_types_pkg;

   import fifo_cfg_pkg::*;

   // write pointer in words, msb is the wrap bit
   typedef logic [W_ADDR_W:0] w_ptr_t;

   // read pointer in bytes, msb is the wrap bit
   typedef logic [R_ADDR_W:0] r_ptr_t;

   // fill level in bytes, 0 up to FIFO_SIZE
   typedef logic [ADDR_W:0] level_t;

   // payload on each port
   typedef logic [W_DATA_W-1:0] w_word_t;
   typedef logic [R_DATA_W-1:0] r_byte_t;

   // one domain's view of the buffer
   typedef struct packed {
      logic   empty;
      logic   full;
      level_t level;
   } fifo_status_t;

endpackage

/* rtl/gray_ptr_counter.sv */
`timescale 1ns/1ps

module gray_ptr_counter #(
   parameter int PTR_W = 3
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             en_i,
   output logic [PTR_W-1:0] bin_o,
   output logic [PTR_W-1:0] gray_o
);

   logic [PTR_W-1:0] bin_nxt;

   // value the pointer takes on an enabled cycle
   assign bin_nxt = bin_o + 1'b1;

   // gray code is registered from the next binary value, so it moves
   // on the same edge as bin_o and never shows a combinational glitch
   // to the far domain
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bin_o  <= '0;
         gray_o <= '0;
      end else if (en_i) begin
         bin_o  <= bin_nxt;
         gray_o <= bin_nxt ^ (bin_nxt >> 1);
      end
   end

endmodule

/* rtl/ptr_sync.sv */
`timescale 1ns/1ps

module ptr_sync #(
   parameter type payload_t = logic
) (
   input  logic     clk_i,
   input  logic     rst_i,
   input  payload_t d_i,
   output payload_t q_o
);

   // first stage may go metastable, only q_o is used downstream
   payload_t meta;

   // two flops in the destination domain
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         meta <= '0;
         q_o  <= '0;
      end else begin
         meta <= d_i;
         q_o  <= meta;
      end
   end

endmodule

/* rtl/fifo_status.sv */
`timescale 1ns/1ps

module fifo_status #(
   parameter int OWN_W     = 3,
   parameter int FAR_W     = 5,
   parameter int OWN_SHIFT = 2,
   parameter int FAR_SHIFT = 0,
   parameter int INCR      = 4
) (
   input  logic [OWN_W-1:0]            own_bin_i,
   input  logic [FAR_W-1:0]            far_gray_i,
   output fifo_types_pkg::fifo_status_t status_o
);

   import fifo_cfg_pkg::*;
   import fifo_types_pkg::*;

   // the write side is the one that consumes W_INCR bytes per access
   localparam bit OWN_IS_WR = (INCR == W_INCR);

   logic [FAR_W-1:0] far_bin;
   level_t           own_bytes;
   level_t           far_bytes;
   level_t           level;

   // gray to binary, each bit is the xor of itself and all bits above
   always_comb begin
      for (int i = 0; i < FAR_W; i++) begin
         far_bin[i] = ^(far_gray_i >> i);
      end
   end

   // both pointers in byte units, modulo twice the depth
   assign own_bytes = level_t'(own_bin_i) << OWN_SHIFT;
   assign far_bytes = level_t'(far_bin) << FAR_SHIFT;

   // level is always write pointer minus read pointer
   assign level = OWN_IS_WR ? (own_bytes - far_bytes) : (far_bytes - own_bytes);

   // a side is empty or full when its next access would not fit
   assign status_o.level = level;
   assign status_o.empty = (level < level_t'(INCR));
   assign status_o.full  = (level > level_t'(FIFO_SIZE - INCR));

endmodule

/* rtl/dual_clock_ram.sv */
`timescale 1ns/1ps

module dual_clock_ram (
   input  logic                                 w_clk_i,
   input  logic                                 w_en_i,
   input  logic [fifo_cfg_pkg::W_ADDR_W-1:0]    w_addr_i,
   input  fifo_types_pkg::w_word_t              w_data_i,
   input  logic                                 r_clk_i,
   input  logic                                 rst_i,
   input  logic                                 r_en_i,
   input  logic [fifo_cfg_pkg::R_ADDR_W-1:0]    r_addr_i,
   output fifo_types_pkg::r_byte_t              r_data_o
);

   import fifo_cfg_pkg::*;
   import fifo_types_pkg::*;

   // storage is byte wide so the read side indexes it directly
   r_byte_t mem [FIFO_SIZE];

   // a word lands in RATIO consecutive bytes, low byte at the lowest address
   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         for (int i = 0; i < RATIO; i++) begin
            mem[{w_addr_i, RATIO_LOG'(i)}] <= w_data_i[i*R_DATA_W +: R_DATA_W];
         end
      end
   end

   // registered read, holds its value until the next accepted read
   always_ff @(posedge r_clk_i) begin
      if (rst_i) begin
         r_data_o <= '0;
      end else if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

/* rtl/async_fifo_top.sv */
`timescale 1ns/1ps

module async_fifo_top (
   input  logic                         w_clk_i,
   input  logic                         r_clk_i,
   input  logic                         rst_i,
   // write port
   input  logic                         w_en_i,
   input  fifo_types_pkg::w_word_t      w_data_i,
   output fifo_types_pkg::fifo_status_t w_status_o,
   // read port
   input  logic                         r_en_i,
   output fifo_types_pkg::r_byte_t      r_data_o,
   output fifo_types_pkg::fifo_status_t r_status_o
);

   import fifo_cfg_pkg::*;
   import fifo_types_pkg::*;

   // pointers in their own domain
   w_ptr_t w_bin;
   w_ptr_t w_gray;
   r_ptr_t r_bin;
   r_ptr_t r_gray;

   // far pointers after crossing
   w_ptr_t w_gray_sync;
   r_ptr_t r_gray_sync;

   // write pointer, advanced by accepted writes only
   gray_ptr_counter #(.PTR_W(W_ADDR_W + 1)) u_w_cnt (
      .clk_i  (w_clk_i),
      .rst_i  (rst_i),
      .en_i   (w_en_i & ~w_status_o.full),
      .bin_o  (w_bin),
      .gray_o (w_gray)
   );

   // read pointer, advanced by accepted reads only
   gray_ptr_counter #(.PTR_W(R_ADDR_W + 1)) u_r_cnt (
      .clk_i  (r_clk_i),
      .rst_i  (rst_i),
      .en_i   (r_en_i & ~r_status_o.empty),
      .bin_o  (r_bin),
      .gray_o (r_gray)
   );

   // write pointer into the read domain
   ptr_sync #(.payload_t(w_ptr_t)) u_w2r_sync (
      .clk_i (r_clk_i),
      .rst_i (rst_i),
      .d_i   (w_gray),
      .q_o   (w_gray_sync)
   );

   // read pointer into the write domain
   ptr_sync #(.payload_t(r_ptr_t)) u_r2w_sync (
      .clk_i (w_clk_i),
      .rst_i (rst_i),
      .d_i   (r_gray),
      .q_o   (r_gray_sync)
   );

   // write side counts words, scaled up to bytes
   fifo_status #(
      .OWN_W     (W_ADDR_W + 1),
      .FAR_W     (R_ADDR_W + 1),
      .OWN_SHIFT (RATIO_LOG),
      .FAR_SHIFT (0),
      .INCR      (W_INCR)
   ) u_w_status (
      .own_bin_i  (w_bin),
      .far_gray_i (r_gray_sync),
      .status_o   (w_status_o)
   );

   fifo_status #(
      .OWN_W     (R_ADDR_W + 1),
      .FAR_W     (W_ADDR_W + 1),
      .OWN_SHIFT (0),
      .FAR_SHIFT (RATIO_LOG),
      .INCR      (R_INCR)
   ) u_r_status (
      .own_bin_i  (r_bin),
      .far_gray_i (w_gray_sync),
      .status_o   (r_status_o)
   );

   // addresses drop the wrap bit
   dual_clock_ram u_ram (
      .w_clk_i  (w_clk_i),
      .w_en_i   (w_en_i & ~w_status_o.full),
      .w_addr_i (w_bin[W_ADDR_W-1:0]),
      .w_data_i (w_data_i),
      .r_clk_i  (r_clk_i),
      .rst_i    (rst_i),
      .r_en_i   (r_en_i & ~r_status_o.empty),
      .r_addr_i (r_bin[R_ADDR_W-1:0]),
      .r_data_o (r_data_o)
   );

endmodule

/* verification/async_fifo_assert.sv */
`timescale 1ns/1ps

module async_fifo_sva (
   input logic                         w_clk_i,
   input logic                         r_clk_i,
   input logic                         rst_i,
   input fifo_types_pkg::fifo_status_t w_status_i,
   input fifo_types_pkg::fifo_status_t r_status_i,
   input fifo_types_pkg::w_ptr_t       w_bin_i,
   input fifo_types_pkg::w_ptr_t       w_gray_i,
   input fifo_types_pkg::r_ptr_t       r_gray_i
);

   import fifo_cfg_pkg::*;
   import fifo_types_pkg::*;

   // one count per assertion, read back by the testbench at the end
   int full_fail_cnt    = 0;
   int w_level_fail_cnt = 0;
   int r_level_fail_cnt = 0;
   int w_gray_fail_cnt  = 0;
   int r_gray_fail_cnt  = 0;
   int fail_total;

   assign fail_total = full_fail_cnt + w_level_fail_cnt + r_level_fail_cnt
                     + w_gray_fail_cnt + r_gray_fail_cnt;

   // a refused write leaves the pointer where it was
   a_no_write_when_full: assert property (@(posedge w_clk_i) disable iff (rst_i)
      w_status_i.full |=> $stable(w_bin_i))
   else begin
      full_fail_cnt++;
      $error("write pointer advanced while the write side was full");
   end

   a_w_level_max: assert property (@(posedge w_clk_i) disable iff (rst_i)
      w_status_i.level <= level_t'(FIFO_SIZE))
   else begin
      w_level_fail_cnt++;
      $error("write side level above the buffer size");
   end

   a_r_level_max: assert property (@(posedge r_clk_i) disable iff (rst_i)
      r_status_i.level <= level_t'(FIFO_SIZE))
   else begin
      r_level_fail_cnt++;
      $error("read side level above the buffer size");
   end

   // crossing values may change only one bit per edge
   a_w_gray_step: assert property (@(posedge w_clk_i) disable iff (rst_i)
      $countones(w_gray_i ^ $past(w_gray_i)) <= 1)
   else begin
      w_gray_fail_cnt++;
      $error("write gray pointer changed more than one bit");
   end

   a_r_gray_step: assert property (@(posedge r_clk_i) disable iff (rst_i)
      $countones(r_gray_i ^ $past(r_gray_i)) <= 1)
   else begin
      r_gray_fail_cnt++;
      $error("read gray pointer changed more than one bit");
   end

endmodule

bind async_fifo_top async_fifo_sva u_sva (
   .w_clk_i    (w_clk_i),
   .r_clk_i    (r_clk_i),
   .rst_i      (rst_i),
   .w_status_i (w_status_o),
   .r_status_i (r_status_o),
   .w_bin_i    (w_bin),
   .w_gray_i   (w_gray),
   .r_gray_i   (r_gray)
);

/* verification/async_fifo_tb.sv */
`timescale 1ns/1ps

module async_fifo_tb;

   import fifo_cfg_pkg::*;
   import fifo_types_pkg::*;

   // about 150 write cycles for each of five tests plus margin
   localparam int CYCLE_LIMIT  = 2000;
   localparam int STREAM_WORDS = 30;

   logic         w_clk;
   logic         r_clk;
   logic         rst;
   logic         w_en;
   w_word_t      w_data;
   fifo_status_t w_status;
   logic         r_en;
   r_byte_t      r_data;
   fifo_status_t r_status;

   // reference contents of the buffer with the oldest byte first
   r_byte_t      ref_q[$];

   // byte that r_data must show after the last accepted read
   r_byte_t      exp_byte;
   logic         exp_pending;

   logic [31:0]  rnd_state;
   logic         w_done;
   int           w_accepted    = 0;
   int           cycle_cnt     = 0;
   int           check_cnt     = 0;
   int           error_cnt     = 0;
   int           test_cnt      = 0;
   int           test_fail_cnt = 0;

   async_fifo_top UUT (
      .w_clk_i    (w_clk),
      .r_clk_i    (r_clk),
      .rst_i      (rst),
      .w_en_i     (w_en),
      .w_data_i   (w_data),
      .w_status_o (w_status),
      .r_en_i     (r_en),
      .r_data_o   (r_data),
      .r_status_o (r_status)
   );

   initial begin
      w_clk = 1'b0;
      forever #50 w_clk = ~w_clk;
   end

   // 130 ns period so its rising edges never meet those of w_clk
   initial begin
      r_clk = 1'b0;
      forever #65 r_clk = ~r_clk;
   end

   always @(posedge w_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout: tests still running after %0d write clock cycles", CYCLE_LIMIT);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rnd_state = xorshift32(rnd_state);
      return rnd_state;
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      check_cnt++;
      if (actual !== expected) begin
         error_cnt++;
         $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   task automatic check_status(input fifo_status_t st, input logic empty, input logic full,
                               input int level, input string what);
      check_value(32'(st.empty), 32'(empty), {what, " empty"});
      check_value(32'(st.full), 32'(full), {what, " full"});
      check_value(32'(st.level), 32'(level), {what, " level"});
   endtask

   task automatic finish_test(input string name, input int errs_before);
      test_cnt++;
      if (error_cnt != errs_before) begin
         test_fail_cnt++;
         $display("test %s: failed", name);
      end else begin
         $display("test %s: ok", name);
      end
   endtask

   // a driven write is taken at this edge if the full flag was clear
   task automatic write_sample();
      @(posedge w_clk);
      if (w_en && !w_status.full) begin
         for (int i = 0; i < RATIO; i++) begin
            ref_q.push_back(w_data[i*R_DATA_W +: R_DATA_W]);
         end
         w_accepted++;
      end
   endtask

   // the byte of a read shows on r_data one read edge later
   task automatic read_sample();
      @(posedge r_clk);
      if (exp_pending) begin
         check_value(32'(r_data), 32'(exp_byte), "read byte");
         exp_pending = 1'b0;
      end
      if (r_en && !r_status.empty) begin
         if (ref_q.size() == 0) begin
            error_cnt++;
            $display("a read was accepted at %0t with no byte left in the reference", $time);
         end else begin
            exp_byte    = ref_q.pop_front();
            exp_pending = 1'b1;
         end
      end
   endtask

   task automatic write_words(input int n);
      for (int i = 0; i < n; i++) begin
         write_sample();
         w_en   <= 1'b1;
         w_data <= next_random();
      end
      write_sample();
      w_en <= 1'b0;
   endtask

   task automatic read_bytes(input int n);
      for (int i = 0; i < n; i++) begin
         read_sample();
         r_en <= 1'b1;
      end
      read_sample();
      r_en <= 1'b0;
      read_sample();
   endtask

   task automatic wait_write_drained();
      do @(posedge w_clk); while (w_status.level != '0);
   endtask

   task automatic test_reset();
      int errs;
      errs = error_cnt;
      @(posedge w_clk);
      check_status(w_status, 1'b1, 1'b0, 0, "write status after reset");
      @(posedge r_clk);
      check_status(r_status, 1'b1, 1'b0, 0, "read status after reset");
      check_value(32'(r_data), 32'h0, "read data after reset");
      finish_test("reset state", errs);
   endtask

   task automatic test_single_word();
      int errs;
      errs = error_cnt;
      write_words(1);
      do @(posedge r_clk); while (r_status.empty);
      check_value(32'(r_status.level), 32'd4, "read level after one word");
      read_bytes(4);
      check_status(r_status, 1'b1, 1'b0, 0, "read status after draining");
      wait_write_drained();
      check_status(w_status, 1'b1, 1'b0, 0, "write status after draining");
      check_value(32'(ref_q.size()), 32'h0, "reference bytes left");
      finish_test("single word", errs);
   endtask

   task automatic test_fill_overflow();
      int errs;
      int start;
      int attempts;
      errs     = error_cnt;
      start    = w_accepted;
      attempts = 0;
      write_sample();
      // keep writing until full shows up so the last attempt is dropped
      while (!w_status.full && attempts < 8) begin
         w_en   <= 1'b1;
         w_data <= next_random();
         attempts++;
         write_sample();
      end
      w_en <= 1'b0;
      check_value(32'(w_accepted - start), 32'd4, "words accepted before full");
      check_value(32'(attempts), 32'd5, "write attempts until full");
      check_status(w_status, 1'b0, 1'b1, 16, "write status when full");
      do @(posedge r_clk); while (r_status.level != level_t'(FIFO_SIZE));
      check_status(r_status, 1'b0, 1'b1, 16, "read status when full");
      read_bytes(FIFO_SIZE);
      check_status(r_status, 1'b1, 1'b0, 0, "read status after sixteen reads");
      check_value(32'(ref_q.size()), 32'h0, "reference bytes left");
      wait_write_drained();
      finish_test("fill and overflow", errs);
   endtask

   task automatic test_underflow();
      int      errs;
      r_byte_t prev;
      errs = error_cnt;
      prev = r_data;
      read_bytes(1);
      check_value(32'(r_data), 32'(prev), "read data after read on empty");
      check_status(r_status, 1'b1, 1'b0, 0, "read status after read on empty");
      finish_test("underflow", errs);
   endtask

   task automatic stream_writer();
      int          start;
      logic [31:0] rnd;
      start = w_accepted;
      write_sample();
      while (w_accepted - start < STREAM_WORDS) begin
         rnd = next_random();
         w_en   <= rnd[0];
         w_data <= next_random();
         write_sample();
      end
      w_en   <= 1'b0;
      w_done = 1'b1;
   endtask

   task automatic stream_reader();
      logic [31:0] rnd;
      read_sample();
      while (!(w_done && ref_q.size() == 0)) begin
         rnd = next_random();
         r_en <= rnd[0] | rnd[1];
         read_sample();
      end
      r_en <= 1'b0;
      read_sample();
   endtask

   task automatic test_streaming();
      int errs;
      errs   = error_cnt;
      w_done = 1'b0;
      fork
         stream_writer();
         stream_reader();
      join
      check_status(r_status, 1'b1, 1'b0, 0, "read status after streaming");
      wait_write_drained();
      check_status(w_status, 1'b1, 1'b0, 0, "write status after streaming");
      finish_test("random streaming", errs);
   endtask

   initial begin
      rst         = 1'b1;
      w_en        = 1'b0;
      w_data      = '0;
      r_en        = 1'b0;
      exp_byte    = '0;
      exp_pending = 1'b0;
      w_done      = 1'b0;
      rnd_state   = 32'h8a96_f354;
      repeat (8) @(posedge r_clk);
      rst <= 1'b0;
      test_reset();
      test_single_word();
      test_fill_overflow();
      test_underflow();
      test_streaming();
      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               test_cnt, test_fail_cnt, check_cnt, error_cnt, UUT.u_sva.fail_total);
      if (error_cnt == 0 && test_fail_cnt == 0 && UUT.u_sva.fail_total == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* build.f */
rtl/fifo_cfg_pkg.sv
rtl/fifo_types_pkg.sv
rtl/gray_ptr_counter.sv
rtl/ptr_sync.sv
rtl/fifo_status.sv
rtl/dual_clock_ram.sv
rtl/async_fifo_top.sv
verification/async_fifo_assert.sv
verification/async_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the dual-clock FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module async_fifo_tb -o sim_async_fifo
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

# a raised error limit lets assertion failures reach the end of the run
./obj_dir/sim_async_fifo +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
   echo "failure reported in $LOG"
   exit 1
fi

echo "no failure reported in $LOG"
exit 0
